/* src.f */
memPkg.sv
memMapRouter.sv
wbManager.sv
wbDecoder.sv
sramWb.sv
regBankWb.sv
memSubsystemTop.sv
tbMemSubsystem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tbMemSubsystem -o simv
./obj_dir/simv | tee sim.log
if grep -qx "test passed" sim.log; then
    echo "simulation finished without errors"
else
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

/* tbMemSubsystem.sv */
`timescale 1ns/10ps

module tbMemSubsystem import memPkg::*; ();

    localparam int NUM_FIXED      = 24;
    localparam int NUM_RANDOM     = 32;
    localparam int NUM_ENTRIES    = NUM_FIXED + 2 * NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 10 + 200;

    logic  clk;
    logic  rst_i;
    rwi_t  rwi_i;
    addr_t addr_i;
    word_t wdata_i;
    word_t rdata_o;
    logic  busy_o;
    logic  done_o;
    logic  addrError_o;

    // stimulus table, expected values filled from the reference model
    rwi_t  tabRwi     [NUM_ENTRIES];
    addr_t tabAddr    [NUM_ENTRIES];
    word_t tabWdata   [NUM_ENTRIES];
    word_t tabExpData [NUM_ENTRIES];
    logic  tabExpErr  [NUM_ENTRIES];
    int    entryCount;

    // reference model of the address map
    word_t refSram [256];
    word_t refRegs [16];

    int     errCount;
    int     checkCount;
    int     cycleCount = 0;
    integer seed;

    memSubsystemTop uut (
        .clk(clk), .rst_i(rst_i), .rwi_i(rwi_i), .addr_i(addr_i), .wdata_i(wdata_i),
        .rdata_o(rdata_o), .busy_o(busy_o), .done_o(done_o), .addrError_o(addrError_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish its accesses in %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic checkValue(input string what, input word_t actual, input word_t expected);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // 0 sram, 1 register bank, 2 unmapped
    function automatic int targetOf(input addr_t a);
        if (a < 32'h0000_0400) begin
            return 0;
        end else if (a >= 32'h0001_0000 && a < 32'h0001_0040) begin
            return 1;
        end
        return 2;
    endfunction

    task automatic addEntry(input rwi_t code, input addr_t a, input word_t d);
        int    tgt;
        word_t exp;
        tgt = targetOf(a);
        exp = '0;
        if (tgt == 0) begin
            if (code == RWI_WRITE) begin
                refSram[a[9:2]] = d;
            end else begin
                exp = refSram[a[9:2]];
            end
        end else if (tgt == 1) begin
            if (code == RWI_WRITE) begin
                refRegs[a[5:2]] = d;
            end else begin
                exp = refRegs[a[5:2]];
            end
        end else if (code == RWI_READ) begin
            exp = 32'hDEAD_BEEF;
        end
        tabRwi[entryCount]     = code;
        tabAddr[entryCount]    = a;
        tabWdata[entryCount]   = d;
        tabExpData[entryCount] = exp;
        tabExpErr[entryCount]  = (tgt == 2);
        entryCount++;
    endtask

    task automatic buildTable();
        addr_t a;
        word_t d;
        addEntry(RWI_WRITE, 32'h0000_0000, 32'hAAAA_0001);
        addEntry(RWI_WRITE, 32'h0000_0004, 32'h5555_0002);
        addEntry(RWI_WRITE, 32'h0000_000C, 32'h3333_0003);
        addEntry(RWI_WRITE, 32'h0000_03FC, 32'hFFFF_00FF);
        addEntry(RWI_READ,  32'h0000_0000, '0);
        addEntry(RWI_READ,  32'h0000_0004, '0);
        // low address bits select the same word
        addEntry(RWI_READ,  32'h0000_000E, '0);
        addEntry(RWI_READ,  32'h0000_03FD, '0);
        addEntry(RWI_WRITE, 32'h0001_0000, 32'h1234_5678);
        addEntry(RWI_WRITE, 32'h0001_000C, 32'h7777_0003);
        addEntry(RWI_WRITE, 32'h0001_003C, 32'hCAFE_000F);
        addEntry(RWI_READ,  32'h0001_000C, '0);
        addEntry(RWI_READ,  32'h0000_000C, '0);
        addEntry(RWI_READ,  32'h0001_0000, '0);
        addEntry(RWI_READ,  32'h0001_003C, '0);
        addEntry(RWI_READ,  32'h0001_0004, '0);
        addEntry(RWI_READ,  32'h0000_0400, '0);
        addEntry(RWI_READ,  32'h0000_0004, '0);
        // just past the register bank, would alias register 0
        addEntry(RWI_WRITE, 32'h0001_0040, 32'h0BAD_0BAD);
        addEntry(RWI_READ,  32'h0001_0000, '0);
        addEntry(RWI_READ,  32'hFFFF_FFFC, '0);
        addEntry(RWI_WRITE, 32'h0002_0000, 32'h0BAD_0002);
        addEntry(RWI_WRITE, 32'h0000_0004, 32'h9999_0004);
        addEntry(RWI_READ,  32'h0000_0004, '0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = addr_t'($random(seed)) & 32'h0000_03FF;
            d = $random(seed);
            addEntry(RWI_WRITE, a, d);
            addEntry(RWI_READ, a, '0);
        end
    endtask

    task automatic runEntry(input int i);
        rwi_i   = tabRwi[i];
        addr_i  = tabAddr[i];
        wdata_i = tabWdata[i];
        @(negedge clk);
        while (!done_o) begin
            checkValue($sformatf("entry %0d error flag before done", i), 32'(addrError_o), '0);
            @(negedge clk);
        end
        checkValue($sformatf("entry %0d error flag", i), 32'(addrError_o), 32'(tabExpErr[i]));
        if (tabRwi[i] == RWI_READ) begin
            checkValue($sformatf("entry %0d read data", i), rdata_o, tabExpData[i]);
        end
        rwi_i = RWI_IDLE;
        @(negedge clk);
    endtask

    // a read level held for 20 cycles runs one access only
    task automatic holdRead();
        int   doneCount;
        logic doneSeen;
        doneCount = 0;
        doneSeen  = 1'b0;
        rwi_i     = RWI_READ;
        addr_i    = 32'h0001_000C;
        repeat (20) begin
            @(negedge clk);
            checkValue("busy while held", 32'(busy_o), 32'(!doneSeen));
            if (done_o) begin
                doneCount++;
                doneSeen = 1'b1;
                checkValue("held read data", rdata_o, refRegs[3]);
            end
        end
        checkValue("done pulses while held", 32'(doneCount), 32'd1);
        rwi_i = RWI_IDLE;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        rst_i      = 1'b1;
        rwi_i      = RWI_IDLE;
        addr_i     = '0;
        wdata_i    = '0;
        errCount   = 0;
        checkCount = 0;
        entryCount = 0;
        seed       = 32'h3c3c;
        for (int i = 0; i < 16; i++) begin
            refRegs[i] = '0;
        end
        buildTable();
        repeat (3) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        checkValue("busy after reset", 32'(busy_o), '0);
        checkValue("done after reset", 32'(done_o), '0);
        checkValue("error flag after reset", 32'(addrError_o), '0);
        checkValue("read data after reset", rdata_o, '0);
        for (int i = 0; i < entryCount; i++) begin
            runEntry(i);
        end
        holdRead();
        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* memSubsystemTop.sv */
`timescale 1ns/10ps

module memSubsystemTop import memPkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  rwi_t  rwi_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output word_t rdata_o,
    output logic  busy_o,
    output logic  done_o,
    output logic  addrError_o
);

    // router to manager
    logic  mgrRead, mgrWrite, mgrBusy, mgrErr;
    addr_t mgrAddr;
    word_t mgrWdata, mgrRdata;

    // manager to decoder and slaves
    logic  wbCyc, wbStb, wbWe, wbAck, wbErr;
    addr_t wbAdr;
    word_t wbDatW, wbDatR;

    // per slave
    logic  sramCyc, sramStb, sramAck;
    logic  regCyc, regStb, regAck;
    word_t sramDat, regDat;

    memMapRouter router (
        .clk(clk), .rst_i(rst_i), .rwi_i(rwi_i), .addr_i(addr_i), .wdata_i(wdata_i),
        .mgrData_i(mgrRdata), .mgrBusy_i(mgrBusy), .mgrErr_i(mgrErr),
        .read_o(mgrRead), .write_o(mgrWrite), .addr_o(mgrAddr), .wdata_o(mgrWdata),
        .rdata_o(rdata_o), .busy_o(busy_o), .done_o(done_o), .addrError_o(addrError_o)
    );

    wbManager manager (
        .clk(clk), .rst_i(rst_i), .read_i(mgrRead), .write_i(mgrWrite),
        .cpuAddr_i(mgrAddr), .cpuData_i(mgrWdata), .dat_i(wbDatR), .ack_i(wbAck),
        .err_i(wbErr), .cyc_o(wbCyc), .stb_o(wbStb), .we_o(wbWe), .adr_o(wbAdr),
        .dat_o(wbDatW), .cpuData_o(mgrRdata), .busy_o(mgrBusy), .busErr_o(mgrErr)
    );

    wbDecoder decoder (
        .cyc_i(wbCyc), .stb_i(wbStb), .adr_i(wbAdr),
        .sramAck_i(sramAck), .sramDat_i(sramDat), .regAck_i(regAck), .regDat_i(regDat),
        .sramCyc_o(sramCyc), .sramStb_o(sramStb), .regCyc_o(regCyc), .regStb_o(regStb),
        .ack_o(wbAck), .dat_o(wbDatR), .err_o(wbErr)
    );

    sramWb sram (
        .clk(clk), .rst_i(rst_i), .cyc_i(sramCyc), .stb_i(sramStb), .we_i(wbWe),
        .adr_i(wbAdr), .dat_i(wbDatW), .ack_o(sramAck), .dat_o(sramDat)
    );

    regBankWb regBank (
        .clk(clk), .rst_i(rst_i), .cyc_i(regCyc), .stb_i(regStb), .we_i(wbWe),
        .adr_i(wbAdr), .dat_i(wbDatW), .ack_o(regAck), .dat_o(regDat)
    );

endmodule

/* regBankWb.sv */
`timescale 1ns/10ps

module regBankWb import memPkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  addr_t adr_i,
    input  word_t dat_i,
    output logic  ack_o,
    output word_t dat_o
);

    word_t   regs [REG_WORDS];
    regIdx_t idx;

    assign idx = adr_i[5:2];

    // no wait state, ack in the strobe cycle
    assign ack_o = cyc_i && stb_i;
    assign dat_o = regs[idx];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (ack_o && we_i) begin
            regs[idx] <= dat_i;
        end
    end

endmodule

/* sramWb.sv */
`timescale 1ns/10ps

module sramWb import memPkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  addr_t adr_i,
    input  word_t dat_i,
    output logic  ack_o,
    output word_t dat_o
);

    word_t    mem [SRAM_WORDS];
    sramIdx_t idx;
    logic     req;

    // word addressing, byte offset dropped
    assign idx = adr_i[9:2];

    // ack_o low on the strobe edge gives the one wait state
    assign req = cyc_i && stb_i && !ack_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (we_i) begin
                mem[idx] <= dat_i;
            end
            dat_o <= mem[idx];
        end
    end

    // the manager keeps the strobe up until it sees the ack
    assert property (@(posedge clk) disable iff (rst_i) ack_o |-> cyc_i && stb_i)
        else $error("sram ack without an open strobe");

endmodule

/* wbDecoder.sv */
`timescale 1ns/10ps

module wbDecoder import memPkg::*; (
    input  logic  cyc_i,
    input  logic  stb_i,
    input  addr_t adr_i,
    input  logic  sramAck_i,
    input  word_t sramDat_i,
    input  logic  regAck_i,
    input  word_t regDat_i,
    output logic  sramCyc_o,
    output logic  sramStb_o,
    output logic  regCyc_o,
    output logic  regStb_o,
    output logic  ack_o,
    output word_t dat_o,
    output logic  err_o
);

    addr_t sramOff;
    addr_t regOff;
    logic  sramHit;
    logic  regHit;
    logic  unmapped;

    // offset compare, an address below the base wraps to a large value
    assign sramOff  = adr_i - SRAM_BASE;
    assign regOff   = adr_i - REG_BASE;
    assign sramHit  = sramOff < addr_t'(SRAM_WORDS * 4);
    assign regHit   = regOff < addr_t'(REG_WORDS * 4);
    assign unmapped = !sramHit && !regHit;

    assign sramCyc_o = cyc_i && sramHit;
    assign sramStb_o = stb_i && sramHit;
    assign regCyc_o  = cyc_i && regHit;
    assign regStb_o  = stb_i && regHit;

    // unmapped addresses are answered here in the strobe cycle
    assign err_o = cyc_i && stb_i && unmapped;

    always_comb begin
        if (sramHit) begin
            ack_o = sramAck_i;
            dat_o = sramDat_i;
        end else if (regHit) begin
            ack_o = regAck_i;
            dat_o = regDat_i;
        end else begin
            ack_o = err_o;
            dat_o = BAD_READ_DATA;
        end
    end

    always_comb begin
        assert (!(sramStb_o && regStb_o))
            else $error("both slaves strobed at once");
    end

endmodule

/* wbManager.sv */
`timescale 1ns/10ps

module wbManager import memPkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  read_i,
    input  logic  write_i,
    input  addr_t cpuAddr_i,
    input  word_t cpuData_i,
    input  word_t dat_i,
    input  logic  ack_i,
    input  logic  err_i,
    output logic  cyc_o,
    output logic  stb_o,
    output logic  we_o,
    output addr_t adr_o,
    output word_t dat_o,
    output word_t cpuData_o,
    output logic  busy_o,
    output logic  busErr_o
);

    typedef enum logic [1:0] {IDLE, CYCLE, RELEASE} state_t;

    state_t state;
    logic   start;
    logic   finish;

    assign start  = (state == IDLE) && (read_i || write_i);
    assign finish = (state == CYCLE) && ack_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= IDLE;
            cyc_o    <= 1'b0;
            stb_o    <= 1'b0;
            busy_o   <= 1'b0;
            busErr_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        cyc_o    <= 1'b1;
                        stb_o    <= 1'b1;
                        busy_o   <= 1'b1;
                        busErr_o <= 1'b0;
                        state    <= CYCLE;
                    end
                end
                // single beat, the cycle closes on the ack edge
                CYCLE: begin
                    if (ack_i) begin
                        cyc_o    <= 1'b0;
                        stb_o    <= 1'b0;
                        busy_o   <= 1'b0;
                        busErr_o <= err_i;
                        state    <= RELEASE;
                    end
                end
                // requester must drop its level before another cycle
                RELEASE: begin
                    if (!read_i && !write_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_o  <= write_i;
            adr_o <= cpuAddr_i;
            dat_o <= cpuData_i;
        end
        if (finish) begin
            cpuData_o <= dat_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst_i) stb_o |-> cyc_o)
        else $error("stb_o raised outside a bus cycle");

    // a slave answers only while the strobe is up
    assert property (@(posedge clk) disable iff (rst_i) ack_i |-> cyc_o && stb_o)
        else $error("ack received outside an open bus cycle");

endmodule

/* memMapRouter.sv */
`timescale 1ns/10ps

module memMapRouter import memPkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  rwi_t  rwi_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    input  word_t mgrData_i,
    input  logic  mgrBusy_i,
    input  logic  mgrErr_i,
    output logic  read_o,
    output logic  write_o,
    output addr_t addr_o,
    output word_t wdata_o,
    output word_t rdata_o,
    output logic  busy_o,
    output logic  done_o,
    output logic  addrError_o
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT, HOLD} state_t;

    state_t state;
    logic   isWrite;
    logic   accept;
    logic   active;

    assign accept = (state == IDLE) && ((rwi_i == RWI_READ) || (rwi_i == RWI_WRITE));

    // request level stays up until the manager has finished
    assign active  = (state == ISSUE) || (state == WAIT);
    assign read_o  = active && !isWrite;
    assign write_o = active && isWrite;
    assign busy_o  = active || done_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= IDLE;
            isWrite     <= 1'b0;
            rdata_o     <= '0;
            done_o      <= 1'b0;
            addrError_o <= 1'b0;
        end else begin
            done_o      <= 1'b0;
            addrError_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        isWrite <= (rwi_i == RWI_WRITE);
                        state   <= ISSUE;
                    end
                end
                // wait for the manager to pick up the level
                ISSUE: begin
                    if (mgrBusy_i) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (!mgrBusy_i) begin
                        done_o      <= 1'b1;
                        addrError_o <= mgrErr_i;
                        if (!isWrite) begin
                            rdata_o <= mgrErr_i ? BAD_READ_DATA : mgrData_i;
                        end
                        state <= HOLD;
                    end
                end
                // a request held past done must not run again
                HOLD: begin
                    if (rwi_i == RWI_IDLE) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_o  <= addr_i;
            wdata_o <= wdata_i;
        end
    end

    // done closes an access the manager has already finished
    assert property (@(posedge clk) disable iff (rst_i) done_o |-> busy_o && !mgrBusy_i)
        else $error("done_o while the manager is still busy");

endmodule

/* memPkg.sv */
package memPkg;

    // data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // CPU request code: read 10, write 01, idle 00
    typedef logic [1:0] rwi_t;

    localparam rwi_t RWI_IDLE  = 2'b00;
    localparam rwi_t RWI_READ  = 2'b10;
    localparam rwi_t RWI_WRITE = 2'b01;

    // word index into each slave
    typedef logic [7:0] sramIdx_t;
    typedef logic [3:0] regIdx_t;

    // address map, byte addresses
    localparam addr_t SRAM_BASE  = 32'h0000_0000;
    localparam int    SRAM_WORDS = 256;

    localparam addr_t REG_BASE   = 32'h0001_0000;
    localparam int    REG_WORDS  = 16;

    // returned by the decoder on a read outside the map
    localparam word_t BAD_READ_DATA = 32'hDEAD_BEEF;

endpackage
